/* src/copper_pkg.sv */
`default_nettype none

package copper_pkg;

    // Copper program counter width, 2K instruction words
    localparam int COPP_W = 11;

    // XR base addresses of the MOVE targets
    localparam logic [15:0] XR_TILE_BASE   = 16'h4000;
    localparam logic [15:0] XR_COLOR_BASE  = 16'h8000;
    localparam logic [15:0] XR_COPPER_BASE = 16'hC000;

    // Beam totals, including blanking
    localparam int H_TOTAL        = 800;
    localparam int V_TOTAL        = 525;
    // Restart lead in pixels before the last line wraps
    localparam int RESTART_H_LEAD = 4;

    // Pending MOVE results between sequencer and XR port
    localparam int XR_QUEUE_DEPTH = 2;
    localparam int QUEUE_PTR_W    = $clog2(XR_QUEUE_DEPTH);
    localparam int QUEUE_CNT_W    = $clog2(XR_QUEUE_DEPTH + 1);

    typedef logic [15:0]       word_t;
    typedef logic [15:0]       xr_addr_t;
    typedef logic [COPP_W-1:0] copp_pc_t;
    typedef logic [10:0]       hpos_t;
    typedef logic [10:0]       vpos_t;
    // Word one in [31:16], word two in [15:0]
    typedef logic [31:0]       insn_t;
    typedef logic [12:0]       xr_offset_t;

    // Opcode in the top three instruction bits
    typedef enum logic [2:0] {
        WAIT  = 3'b000,
        SKIP  = 3'b001,
        JUMP  = 3'b010,
        MOVER = 3'b011,
        MOVEF = 3'b100,
        MOVEP = 3'b101,
        MOVEC = 3'b110,
        RSVD  = 3'b111
    } opcode_t;

    typedef enum logic [1:0] {
        REG    = 2'd0,
        TILE   = 2'd1,
        COLOR  = 2'd2,
        COPPER = 2'd3
    } move_kind_t;

    typedef enum logic [2:0] {
        INIT    = 3'd0,
        FETCH   = 3'd1,
        LATCH   = 3'd2,
        PRECOMP = 3'd3,
        EXEC    = 3'd4
    } seq_state_t;

endpackage

`default_nettype wire

/* src/xr_move_if.sv */
`timescale 1ns/1ps
`default_nettype none

// One MOVE result, transferred when valid and take are both high
interface xr_move_if;

    logic                   valid;
    copper_pkg::move_kind_t kind;
    // Offset within the target, already cut to the kind's width
    copper_pkg::xr_offset_t offset;
    copper_pkg::word_t      data;
    logic                   take;

    // Producer side, holds its fields while waiting for take
    modport source (
        output valid, kind, offset, data,
        input  take
    );

    modport sink (
        input  valid, kind, offset, data,
        output take
    );

endinterface

`default_nettype wire

/* src/copper_sequencer.sv */
`timescale 1ns/1ps
`default_nettype none

module copper_sequencer import copper_pkg::*; (
    input  wire logic  clk,
    input  wire logic  copp_reset,
    input  wire logic  copp_reg_wr_i,
    input  wire word_t copp_reg_data_i,
    input  wire hpos_t h_count_i,
    input  wire vpos_t v_count_i,
    output logic       mem_rd_en_o,
    output copp_pc_t   mem_rd_addr_o,
    input  wire insn_t mem_rd_data_i,
    xr_move_if.source  move_o
);

    // Control register
    logic       copper_en;
    copp_pc_t   init_pc;

    seq_state_t state;
    copp_pc_t   pc;
    insn_t      insn;

    // Frame restart, a few pixels before the last line wraps
    logic       frame_restart;

    // Registered in PRECOMP, used in EXEC
    logic       v_reached;
    logic       h_reached;
    copp_pc_t   pc_skip;

    // Instruction fields
    opcode_t    opcode;
    logic       ignore_v;
    logic       ignore_h;
    vpos_t      wait_v;
    hpos_t      wait_h;
    copp_pc_t   jump_pc;
    logic       pos_met;
    logic       is_move;
    move_kind_t move_kind;
    xr_offset_t move_offset;

    assign frame_restart = (h_count_i == hpos_t'(H_TOTAL - RESTART_H_LEAD)) &&
                           (v_count_i == vpos_t'(V_TOTAL - 1));

    // Read strobe is high for the single FETCH cycle
    assign mem_rd_en_o   = (state == FETCH);
    assign mem_rd_addr_o = pc;

    assign opcode   = opcode_t'(insn[31:29]);
    assign ignore_v = insn[0];
    assign ignore_h = insn[1];
    assign wait_v   = insn[16 +: $bits(vpos_t)];
    assign wait_h   = insn[4 +: $bits(hpos_t)];
    assign jump_pc  = insn[17 +: COPP_W];
    // Ignored axes count as reached
    assign pos_met  = (ignore_v || v_reached) && (ignore_h || h_reached);

    // MOVE decode, offset zero extended from the kind's own width
    always_comb begin
        is_move     = 1'b1;
        move_kind   = REG;
        move_offset = '0;
        case (opcode)
            MOVER: begin
                move_kind   = REG;
                move_offset = xr_offset_t'(insn[23:16]);
            end
            MOVEF: begin
                move_kind   = TILE;
                move_offset = insn[28:16];
            end
            MOVEP: begin
                move_kind   = COLOR;
                move_offset = xr_offset_t'(insn[24:16]);
            end
            MOVEC: begin
                move_kind   = COPPER;
                move_offset = xr_offset_t'(insn[16 +: COPP_W]);
            end
            default: begin
                is_move = 1'b0;
            end
        endcase
    end

    // Offered only in EXEC, so fields stay put until taken
    assign move_o.valid  = (state == EXEC) && is_move;
    assign move_o.kind   = move_kind;
    assign move_o.offset = move_offset;
    assign move_o.data   = insn[15:0];

    always_ff @(posedge clk) begin
        if (copp_reset) begin
            copper_en <= 1'b0;
            init_pc   <= '0;
        end else if (copp_reg_wr_i) begin
            copper_en <= copp_reg_data_i[15];
            init_pc   <= copp_reg_data_i[COPP_W-1:0];
        end
    end

    always_ff @(posedge clk) begin
        if (copp_reset) begin
            state <= INIT;
            pc    <= '0;
        end else if (frame_restart) begin
            // Restart wins over any state
            state <= INIT;
            pc    <= init_pc;
        end else begin
            case (state)
                INIT: begin
                    if (copper_en) begin
                        state <= FETCH;
                    end
                end
                FETCH: begin
                    // Advance PC now, memory already has this address
                    if (copper_en) begin
                        state <= LATCH;
                        pc    <= pc + 1'b1;
                    end else begin
                        state <= INIT;
                    end
                end
                LATCH: begin
                    state <= PRECOMP;
                end
                PRECOMP: begin
                    state <= EXEC;
                end
                EXEC: begin
                    case (opcode)
                        WAIT: begin
                            // Both axes ignored means wait for the frame end
                            if (pos_met && !(ignore_v && ignore_h)) begin
                                state <= FETCH;
                            end else begin
                                state <= PRECOMP;
                            end
                        end
                        SKIP: begin
                            if (pos_met) begin
                                pc <= pc_skip;
                            end
                            state <= FETCH;
                        end
                        JUMP: begin
                            pc    <= jump_pc;
                            state <= FETCH;
                        end
                        MOVER, MOVEF, MOVEP, MOVEC: begin
                            // Stall here while the queue is full
                            if (move_o.take) begin
                                state <= FETCH;
                            end
                        end
                        default: begin
                            state <= FETCH;
                        end
                    endcase
                end
                default: begin
                    state <= INIT;
                end
            endcase
        end
    end

    // Instruction latch and precomputed compare results
    always_ff @(posedge clk) begin
        if (state == LATCH) begin
            insn <= mem_rd_data_i;
        end
        if (state == PRECOMP) begin
            v_reached <= (v_count_i >= wait_v);
            h_reached <= (h_count_i >= wait_h);
            pc_skip   <= pc + 1'b1;
        end
    end

endmodule

`default_nettype wire

/* src/xr_write_queue.sv */
`timescale 1ns/1ps
`default_nettype none

module xr_write_queue import copper_pkg::*; (
    input  wire logic clk,
    input  wire logic copp_reset,
    xr_move_if.sink   push_i,
    xr_move_if.source pop_o
);

    // Entry storage, split per field
    move_kind_t               kind_mem   [XR_QUEUE_DEPTH];
    xr_offset_t               offset_mem [XR_QUEUE_DEPTH];
    word_t                    data_mem   [XR_QUEUE_DEPTH];

    logic [QUEUE_PTR_W-1:0]   wr_ptr;
    logic [QUEUE_PTR_W-1:0]   rd_ptr;
    logic [QUEUE_CNT_W-1:0]   count;

    logic                     full;
    logic                     do_push;
    logic                     do_pop;

    assign full    = (count == QUEUE_CNT_W'(XR_QUEUE_DEPTH));
    assign do_push = push_i.valid && push_i.take;
    assign do_pop  = pop_o.valid && pop_o.take;

    assign push_i.take = !full;

    // Oldest entry is offered first
    assign pop_o.valid  = (count != '0);
    assign pop_o.kind   = kind_mem[rd_ptr];
    assign pop_o.offset = offset_mem[rd_ptr];
    assign pop_o.data   = data_mem[rd_ptr];

    always_ff @(posedge clk) begin
        if (do_push) begin
            kind_mem[wr_ptr]   <= push_i.kind;
            offset_mem[wr_ptr] <= push_i.offset;
            data_mem[wr_ptr]   <= push_i.data;
        end
    end

    // Pointers wrap naturally, depth is a power of two
    always_ff @(posedge clk) begin
        if (copp_reset) begin
            wr_ptr <= '0;
            rd_ptr <= '0;
            count  <= '0;
        end else begin
            if (do_push) begin
                wr_ptr <= wr_ptr + 1'b1;
            end
            if (do_pop) begin
                rd_ptr <= rd_ptr + 1'b1;
            end
            case ({do_push, do_pop})
                2'b10:   count <= count + 1'b1;
                2'b01:   count <= count - 1'b1;
                default: count <= count;
            endcase
        end
    end

endmodule

`default_nettype wire

/* src/xr_write_port.sv */
`timescale 1ns/1ps
`default_nettype none

module xr_write_port import copper_pkg::*; (
    input  wire logic     clk,
    input  wire logic     copp_reset,
    xr_move_if.sink       move_i,
    output logic          xr_wr_en_o,
    input  wire logic     xr_wr_ack_i,
    output xr_addr_t      xr_wr_addr_o,
    output word_t         xr_wr_data_o
);

    xr_addr_t full_addr;
    logic     load;

    // Full XR address, target base above the offset bits
    always_comb begin
        case (move_i.kind)
            REG:     full_addr = {8'h00, move_i.offset[7:0]};
            TILE:    full_addr = {XR_TILE_BASE[15:13], move_i.offset[12:0]};
            COLOR:   full_addr = {XR_COLOR_BASE[15:9], move_i.offset[8:0]};
            default: full_addr = {XR_COPPER_BASE[15:COPP_W], move_i.offset[COPP_W-1:0]};
        endcase
    end

    // Free now, or free after this cycle's acknowledge
    assign move_i.take = !xr_wr_en_o || xr_wr_ack_i;
    assign load        = move_i.valid && move_i.take;

    always_ff @(posedge clk) begin
        if (copp_reset) begin
            xr_wr_en_o <= 1'b0;
        end else if (load) begin
            xr_wr_en_o <= 1'b1;
        end else if (xr_wr_ack_i) begin
            xr_wr_en_o <= 1'b0;
        end
    end

    // Held until the next load
    always_ff @(posedge clk) begin
        if (load) begin
            xr_wr_addr_o <= full_addr;
            xr_wr_data_o <= move_i.data;
        end
    end

endmodule

`default_nettype wire

/* src/copper_top.sv */
`timescale 1ns/1ps
`default_nettype none

module copper_top import copper_pkg::*; (
    input  wire logic  clk,
    input  wire logic  copp_reset,
    // Control register write
    input  wire logic  copp_reg_wr_i,
    input  wire word_t copp_reg_data_i,
    // Beam position
    input  wire hpos_t h_count_i,
    input  wire vpos_t v_count_i,
    // Copper program memory, data one cycle after the strobe
    output logic       coppermem_rd_en_o,
    output copp_pc_t   coppermem_rd_addr_o,
    input  wire insn_t coppermem_rd_data_i,
    // XR register bus
    output logic       xr_wr_en_o,
    input  wire logic  xr_wr_ack_i,
    output xr_addr_t   xr_wr_addr_o,
    output word_t      xr_wr_data_o
);

    // Sequencer to queue, then queue to XR port
    xr_move_if seq_move ();
    xr_move_if port_move ();

    copper_sequencer i_copper_sequencer (
        .clk             (clk),
        .copp_reset      (copp_reset),
        .copp_reg_wr_i   (copp_reg_wr_i),
        .copp_reg_data_i (copp_reg_data_i),
        .h_count_i       (h_count_i),
        .v_count_i       (v_count_i),
        .mem_rd_en_o     (coppermem_rd_en_o),
        .mem_rd_addr_o   (coppermem_rd_addr_o),
        .mem_rd_data_i   (coppermem_rd_data_i),
        .move_o          (seq_move.source)
    );

    xr_write_queue i_xr_write_queue (
        .clk        (clk),
        .copp_reset (copp_reset),
        .push_i     (seq_move.sink),
        .pop_o      (port_move.source)
    );

    xr_write_port i_xr_write_port (
        .clk          (clk),
        .copp_reset   (copp_reset),
        .move_i       (port_move.sink),
        .xr_wr_en_o   (xr_wr_en_o),
        .xr_wr_ack_i  (xr_wr_ack_i),
        .xr_wr_addr_o (xr_wr_addr_o),
        .xr_wr_data_o (xr_wr_data_o)
    );

endmodule

`default_nettype wire

/* verif/copper_assert.sv */
`timescale 1ns/1ps
`default_nettype none

module copper_assert import copper_pkg::*; (
    input wire logic     clk,
    input wire logic     copp_reset,
    input wire logic     coppermem_rd_en_o,
    input wire logic     xr_wr_en_o,
    input wire logic     xr_wr_ack_i,
    input wire xr_addr_t xr_wr_addr_o,
    input wire word_t    xr_wr_data_o
);

    // Unacknowledged write holds its enable, address and data
    a_write_held: assert property (@(posedge clk) disable iff (copp_reset)
        (xr_wr_en_o && !xr_wr_ack_i) |=>
            (xr_wr_en_o && $stable(xr_wr_addr_o) && $stable(xr_wr_data_o)))
        else $error("XR write changed before its acknowledge");

    // Read strobe lasts one cycle
    a_rd_single: assert property (@(posedge clk) disable iff (copp_reset)
        coppermem_rd_en_o |=> !coppermem_rd_en_o)
        else $error("Copper memory strobe high for two cycles");

    a_reset_idle: assert property (@(posedge clk)
        copp_reset |=> (!coppermem_rd_en_o && !xr_wr_en_o))
        else $error("Control outputs active after reset");

endmodule

bind copper_top copper_assert i_copper_assert (.*);

`default_nettype wire

/* verif/copper_tb.sv */
`timescale 1ns/1ps
`default_nettype none

module copper_tb import copper_pkg::*; ();

    localparam int NUM_ROWS   = 6;
    localparam int PRE_CYC    = 60;
    localparam int WAIT_LIMIT = 300;
    localparam int SETTLE_CYC = 40;
    // WAIT with both ignore flags, parks the program until the frame end
    localparam logic [31:0] PARK = 32'h0000_0003;

    // One test program with its beam script and expected XR writes
    typedef struct packed {
        logic [0:5][31:0] prog;
        logic [10:0]      init_pc;
        logic             enable;
        logic [10:0]      v_before;
        logic [10:0]      v_after;
        logic [2:0]       n_pre;
        logic [2:0]       n_exp;
        logic [0:3][15:0] exp_addr;
        logic [0:3][15:0] exp_data;
        logic             again;
    } row_t;

    logic     clk;
    logic     copp_reset;
    logic     copp_reg_wr_i;
    word_t    copp_reg_data_i;
    hpos_t    h_count_i;
    vpos_t    v_count_i;
    logic     coppermem_rd_en_o;
    copp_pc_t coppermem_rd_addr_o;
    insn_t    coppermem_rd_data_i;
    logic     xr_wr_en_o;
    logic     xr_wr_ack_i;
    xr_addr_t xr_wr_addr_o;
    word_t    xr_wr_data_o;

    insn_t    mem [2**COPP_W];
    insn_t    rd_word;
    row_t     rows [NUM_ROWS];
    xr_addr_t got_addr [$];
    word_t    got_data [$];
    int       errors;
    int       cycles;
    int       rd_count;
    int       ack_delay;
    logic     pending;
    logic     acked;

    copper_top i_copper_top (.*);

    initial begin
        clk = 1'b0;
        forever #2 clk = ~clk;
    end

    // Copper memory, registered read
    always @(posedge clk) begin
        if (coppermem_rd_en_o) begin
            rd_word  = mem[coppermem_rd_addr_o];
            rd_count = rd_count + 1;
            #1;
            coppermem_rd_data_i = rd_word;
        end
    end

    // XR bus slave, random acknowledge delay per write
    always @(posedge clk) begin
        acked = xr_wr_en_o && xr_wr_ack_i;
        if (acked) begin
            got_addr.push_back(xr_wr_addr_o);
            got_data.push_back(xr_wr_data_o);
        end
        #1;
        if (acked || !pending) begin
            pending = xr_wr_en_o;
            ack_delay = $urandom % 4;
        end
        if (pending && ack_delay == 0) begin
            xr_wr_ack_i = 1'b1;
        end else begin
            xr_wr_ack_i = 1'b0;
            if (pending) begin
                ack_delay = ack_delay - 1;
            end
        end
    end

    // Run limit
    always @(posedge clk) begin
        cycles = cycles + 1;
        if (cycles >= NUM_ROWS * 400) begin
            $display("Timeout: the run did not finish within %0d cycles", cycles);
            $display("Some tests failed");
            $finish;
        end
    end

    task automatic write_ctrl(input word_t value);
        @(posedge clk);
        #1;
        copp_reg_wr_i   = 1'b1;
        copp_reg_data_i = value;
        @(posedge clk);
        #1;
        copp_reg_wr_i   = 1'b0;
    endtask

    // One cycle at the restart position, then back to the script line
    task automatic force_restart(input vpos_t v_back);
        @(posedge clk);
        #1;
        h_count_i = hpos_t'(H_TOTAL - RESTART_H_LEAD);
        v_count_i = vpos_t'(V_TOTAL - 1);
        @(posedge clk);
        #1;
        h_count_i = 11'd10;
        v_count_i = v_back;
    endtask

    task automatic wait_writes(input int n);
        int waited;
        waited = 0;
        while (got_addr.size() < n && waited < WAIT_LIMIT) begin
            @(posedge clk);
            waited++;
        end
        // Extra writes would show up here
        repeat (SETTLE_CYC) @(posedge clk);
        #1;
    endtask

    task automatic compare_writes(input int r);
        int n;
        n = int'(rows[r].n_exp);
        assert (got_addr.size() == n) else begin
            errors++;
            $display("Wrong number of XR writes in row %0d: expected %0d, got %0d",
                     r, n, got_addr.size());
        end
        for (int i = 0; i < n && i < got_addr.size(); i++) begin
            assert (got_addr[i] == rows[r].exp_addr[i]) else begin
                errors++;
                $display("CHECK FAILED xr_wr_addr_o row %0d write %0d: expected %h, got %h",
                         r, i, rows[r].exp_addr[i], got_addr[i]);
            end
            assert (got_data[i] == rows[r].exp_data[i]) else begin
                errors++;
                $display("CHECK FAILED xr_wr_data_o row %0d write %0d: expected %h, got %h",
                         r, i, rows[r].exp_data[i], got_data[i]);
            end
        end
    endtask

    initial begin
        // Disabled: nothing fetched, nothing written
        rows[0] = '{prog: {32'h6001_0001, PARK, PARK, PARK, PARK, PARK}, init_pc: 11'h000,
                    enable: 1'b0, v_before: 11'd50, v_after: 11'd50, n_pre: 3'd0, n_exp: 3'd0,
                    exp_addr: '0, exp_data: '0, again: 1'b0};
        // All four MOVE kinds in order
        rows[1] = '{prog: {32'h6025_1111, 32'h9ABC_2222, 32'hA1F3_3333, 32'hC5A5_4444, PARK, PARK},
                    init_pc: 11'h010, enable: 1'b1, v_before: 11'd50, v_after: 11'd50,
                    n_pre: 3'd4, n_exp: 3'd4,
                    exp_addr: {16'h0025, 16'h5ABC, 16'h81F3, 16'hC5A5},
                    exp_data: {16'h1111, 16'h2222, 16'h3333, 16'h4444}, again: 1'b0};
        // WAIT for line 100, then a parked MOVE that never runs
        rows[2] = '{prog: {32'h0064_0002, 32'h6001_AAAA, PARK, 32'h6002_BBBB, PARK, PARK},
                    init_pc: 11'h100, enable: 1'b1, v_before: 11'd50, v_after: 11'd120,
                    n_pre: 3'd0, n_exp: 3'd1,
                    exp_addr: {16'h0001, 48'h0}, exp_data: {16'hAAAA, 48'h0}, again: 1'b0};
        // SKIP met drops its MOVE, SKIP unmet keeps it
        rows[3] = '{prog: {32'h2000_0002, 32'h6003_DEAD, 32'h27FF_0002, 32'h6004_BEEF, PARK, PARK},
                    init_pc: 11'h200, enable: 1'b1, v_before: 11'd50, v_after: 11'd50,
                    n_pre: 3'd1, n_exp: 3'd1,
                    exp_addr: {16'h0004, 48'h0}, exp_data: {16'hBEEF, 48'h0}, again: 1'b0};
        // JMP over two MOVEs onto a RSVD
        rows[4] = '{prog: {32'h4606_0000, 32'h6005_0BAD, 32'h6006_0BAD, 32'hE000_0000,
                           32'h6007_C0DE, PARK},
                    init_pc: 11'h300, enable: 1'b1, v_before: 11'd50, v_after: 11'd50,
                    n_pre: 3'd1, n_exp: 3'd1,
                    exp_addr: {16'h0007, 48'h0}, exp_data: {16'hC0DE, 48'h0}, again: 1'b0};
        // Second restart repeats the same writes
        rows[5] = '{prog: {32'h6008_1234, 32'h9ABC_5678, PARK, PARK, PARK, PARK},
                    init_pc: 11'h400, enable: 1'b1, v_before: 11'd50, v_after: 11'd50,
                    n_pre: 3'd2, n_exp: 3'd2,
                    exp_addr: {16'h0008, 16'h5ABC, 32'h0}, exp_data: {16'h1234, 16'h5678, 32'h0},
                    again: 1'b1};
    end

    initial begin
        void'($urandom(65));
        errors              = 0;
        cycles              = 0;
        rd_count            = 0;
        pending             = 1'b0;
        copp_reset          = 1'b1;
        copp_reg_wr_i       = 1'b0;
        copp_reg_data_i     = '0;
        h_count_i           = 11'd10;
        v_count_i           = 11'd50;
        coppermem_rd_data_i = '0;
        xr_wr_ack_i         = 1'b0;
        repeat (2) @(posedge clk);
        #1;
        copp_reset = 1'b0;

        for (int r = 0; r < NUM_ROWS; r++) begin
            // Park the sequencer in INIT before touching memory
            write_ctrl(16'h0000);
            force_restart(rows[r].v_before);
            // Fill with RSVD words that carry their own address
            for (int a = 0; a < 2**COPP_W; a++) begin
                mem[a] = {3'b111, 18'h0, a[10:0]};
            end
            for (int i = 0; i < 6; i++) begin
                mem[rows[r].init_pc + i] = rows[r].prog[i];
            end
            got_addr.delete();
            got_data.delete();
            // Only the last write counts
            write_ctrl({1'b1, 4'h0, 11'h7F0});
            write_ctrl({rows[r].enable, 4'h0, rows[r].init_pc});
            force_restart(rows[r].v_before);
            rd_count = 0;
            repeat (PRE_CYC) @(posedge clk);
            #1;
            assert (got_addr.size() == int'(rows[r].n_pre)) else begin
                errors++;
                $display("Row %0d: %0d XR writes before the beam step, expected %0d",
                         r, got_addr.size(), rows[r].n_pre);
            end
            v_count_i = rows[r].v_after;
            wait_writes(rows[r].n_exp);
            compare_writes(r);
            if (!rows[r].enable) begin
                assert (rd_count == 0) else begin
                    errors++;
                    $display("Row %0d: copper memory was read while disabled", r);
                end
            end
            if (rows[r].again) begin
                got_addr.delete();
                got_data.delete();
                force_restart(rows[r].v_before);
                wait_writes(rows[r].n_exp);
                compare_writes(r);
            end
        end

        $display("Test run finished with %0d errors", errors);
        if (errors == 0) begin
            $display("All tests passed");
        end else begin
            $display("Some tests failed");
        end
        $finish;
    end

endmodule

`default_nettype wire

/* src.f */
src/copper_pkg.sv
src/xr_move_if.sv
src/copper_sequencer.sv
src/xr_write_queue.sv
src/xr_write_port.sv
src/copper_top.sv
verif/copper_assert.sv
verif/copper_tb.sv

/* Makefile */
VERILATOR ?= verilator
TOP       ?= copper_tb
FILELIST  ?= src.f
BUILD_DIR ?= obj_dir
LOG       ?= sim.log
VFLAGS    ?= --binary --timing --assert

SOURCES := $(shell grep -v '^+' $(FILELIST))
SIM_BIN := $(BUILD_DIR)/V$(TOP)

.PHONY: all build run clean

all: run

build: $(SIM_BIN)

$(SIM_BIN): $(SOURCES) $(FILELIST)
	$(VERILATOR) $(VFLAGS) --top-module $(TOP) -f $(FILELIST) --Mdir $(BUILD_DIR)

run: $(SIM_BIN)
	./$(SIM_BIN) > $(LOG) 2>&1; cat $(LOG)
	grep -q "All tests passed" $(LOG)

clean:
	rm -rf $(BUILD_DIR) $(LOG)
